// ==== testbench/sd_trace.txt ====
# cells: 81 hex nibbles in raster order, 0 marks a blank
# expected: 15 hex nibbles in blank order, all a when the puzzle has no answer
023406789406780123780123056234067801567801230091230567345678012678912305912345670 155994599484948
033406789406780123780123056234067801567801230091230567345678012678912305912345670 aaaaaaaaaaaaaaa
087604321604320987320987054876043209543209870019870543765432098432198705198765430 955116511626162
023406789406780123780123056234067801567801230091230567345678092678912305912345670 aaaaaaaaaaaaaaa
003456789426789103789123406234060891567801034891034560340678012678902305902345678 aaaaaaaaaaaaaaa
023406789406780123780123056234067801567801230091230567345678012678912305912345670 155994599484948

// ==== sd.f ====
verilog/sd_grid_pkg.sv
verilog/sd_ctrl_pkg.sv
verilog/sd_cell_loader.sv
verilog/sd_backtrack.sv
verilog/sd_answer_out.sv
verilog/sd.sv
testbench/sd_checker.sv
testbench/sd_monitor.sv
testbench/sd_tb.sv

// ==== Bender.yml ====
package:
  name: sd

sources:
  - files:
      - verilog/sd_grid_pkg.sv
      - verilog/sd_ctrl_pkg.sv
      - verilog/sd_cell_loader.sv
      - verilog/sd_backtrack.sv
      - verilog/sd_answer_out.sv
      - verilog/sd.sv
  - target: test
    files:
      - testbench/sd_checker.sv
      - testbench/sd_monitor.sv
      - testbench/sd_tb.sv

// ==== testbench/sd_tb.sv ====
`timescale 1ns/1ps

module sd_tb;

	//--------------------------------------------------------------------------
	// DUT signals
	//--------------------------------------------------------------------------
	logic                      clk;
	logic                      rst_n;
	logic                      in_valid;
	sd_grid_pkg::digit_t       in;
	logic                      out_valid;
	sd_grid_pkg::digit_t       out;
	sd_grid_pkg::answer_list_t exp_answers;
	int                        tests_done;
	int                        tests_failed;
	int                        idle_errors;

	// trace contents, one entry per puzzle
	logic [323:0] puzzles [$];
	logic [59:0]  expects [$];
	int           cycles;
	int           cycle_limit;

	sd DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in        (in),
		.out_valid (out_valid),
		.out       (out)
	);

	sd_monitor u_monitor (
		.clk          (clk),
		.rst_n        (rst_n),
		.out_valid    (out_valid),
		.out          (out),
		.exp_answers  (exp_answers),
		.tests_done   (tests_done),
		.tests_failed (tests_failed),
		.idle_errors  (idle_errors)
	);

	bind sd sd_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.out       (out)
	);

	// 40 ns period
	initial clk = 1'b0;
	always #20 clk = ~clk;

	//--------------------------------------------------------------------------
	// trace and stimulus
	//--------------------------------------------------------------------------
	// skips comment lines starting with #
	task automatic load_trace();
		int fd;
		string line;
		logic [323:0] cells;
		logic [59:0] expv;
		fd = $fopen("testbench/sd_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file");
		end else begin
			while ($fgets(line, fd)) begin
				if ((line.len() > 1) && (line[0] != "#")) begin
					if ($sscanf(line, "%h %h", cells, expv) == 2) begin
						puzzles.push_back(cells);
						expects.push_back(expv);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// 81 cells, then wait for the monitor to close the test
	task automatic run_puzzle(input int idx);
		for (int k = 0; k < sd_grid_pkg::NUM_BLANKS; k++) begin
			exp_answers[k] = expects[idx][59 - 4*k -: 4];
		end
		for (int i = 0; i < sd_grid_pkg::NUM_CELLS; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in <= puzzles[idx][323 - 4*i -: 4];
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in <= '0;
		while (tests_done < idx + 1) begin
			@(posedge clk);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in = '0;
		exp_answers = '0;
		load_trace();
		// search budget per puzzle, reset and idle cycles
		cycle_limit = puzzles.size() * (81 + 15 + 20000) + 3 + 6;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// quiet stretch before the first cell
		repeat (4) @(posedge clk);
		for (int p = 0; p < puzzles.size(); p++) begin
			run_puzzle(p);
		end
		repeat (2) @(posedge clk);
		$display("tests %0d, passed %0d, failed %0d, idle errors %0d, assertion failures %0d",
			tests_done, tests_done - tests_failed, tests_failed, idle_errors,
			DUT.u_checker.assert_fails);
		if ((tests_failed == 0) && (idle_errors == 0) &&
			(DUT.u_checker.assert_fails == 0) && (puzzles.size() != 0) &&
			(tests_done == puzzles.size())) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// run limit
	initial cycles = 0;
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, result missing for test %0d",
				cycles, tests_done);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== testbench/sd_monitor.sv ====
`timescale 1ns/1ps

module sd_monitor (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      out_valid,
	input  sd_grid_pkg::digit_t       out,
	input  sd_grid_pkg::answer_list_t exp_answers,
	output int                        tests_done,
	output int                        tests_failed,
	output int                        idle_errors
);

	//--------------------------------------------------------------------------
	// burst capture
	//--------------------------------------------------------------------------
	sd_grid_pkg::digit_t got [sd_grid_pkg::NUM_BLANKS];
	int                  beats;

	initial begin
		tests_done = 0;
		tests_failed = 0;
		idle_errors = 0;
		beats = 0;
	end

	// compare the finished burst with the trace
	task automatic finish_test();
		int errs;
		int exp_len;
		int n;
		errs = 0;
		// a failed puzzle gives a single error beat
		exp_len = (exp_answers[0] == sd_ctrl_pkg::ERR_CODE) ? 1 : sd_grid_pkg::NUM_BLANKS;
		if (beats != exp_len) begin
			$display("test %0d: burst of %0d beats, expected %0d beats",
				tests_done, beats, exp_len);
			errs++;
		end
		n = (beats < exp_len) ? beats : exp_len;
		for (int i = 0; i < n; i++) begin
			if (got[i] !== exp_answers[i]) begin
				$display("mismatch test %0d beat %0d: out = 0x%h, expected 0x%h",
					tests_done, i, got[i], exp_answers[i]);
				errs++;
			end
		end
		if (errs == 0) begin
			$display("test %0d passed", tests_done);
		end else begin
			$display("test %0d failed with %0d errors", tests_done, errs);
			tests_failed++;
		end
		tests_done++;
		beats = 0;
	endtask

	// sampled on the falling edge, away from the driving edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (beats < sd_grid_pkg::NUM_BLANKS) begin
					got[beats] = out;
				end
				beats++;
			end else begin
				if (out !== '0) begin
					$display("mismatch idle: out = 0x%h, expected 0x0", out);
					idle_errors++;
				end
				// burst just ended
				if (beats != 0) begin
					finish_test();
				end
			end
		end
	end

endmodule

// ==== testbench/sd_checker.sv ====
`timescale 1ns/1ps

module sd_checker (
	input logic                clk,
	input logic                rst_n,
	input logic                in_valid,
	input logic                out_valid,
	input sd_grid_pkg::digit_t out
);

	// number of assertion failures so far
	int assert_fails;

	initial assert_fails = 0;

	//--------------------------------------------------------------------------
	// output protocol
	//--------------------------------------------------------------------------
	// no answer while a puzzle is coming in
	assert property (@(posedge clk) disable iff (!rst_n) !(out_valid && in_valid))
		else begin
			$error("out_valid high while in_valid high");
			assert_fails++;
		end

	// idle output stays at zero
	assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> (out == '0))
		else begin
			$error("out not zero while out_valid low");
			assert_fails++;
		end

	// error code is a lone beat
	assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && (out == sd_ctrl_pkg::ERR_CODE)) |-> !$past(out_valid) ##1 !out_valid)
		else begin
			$error("error beat not isolated");
			assert_fails++;
		end

	// answer burst is exactly fifteen beats
	assert property (@(posedge clk) disable iff (!rst_n)
		($rose(out_valid) && (out != sd_ctrl_pkg::ERR_CODE)) |->
		out_valid [*sd_grid_pkg::NUM_BLANKS] ##1 !out_valid)
		else begin
			$error("answer burst length wrong");
			assert_fails++;
		end

endmodule

// ==== verilog/sd.sv ====
`timescale 1ns/1ps

module sd (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  sd_grid_pkg::digit_t in,
	output logic                out_valid,
	output sd_grid_pkg::digit_t out
);

	//--------------------------------------------------------------------------
	// loader to backtracker
	//--------------------------------------------------------------------------
	logic                     load_done;
	logic                     dup_err;
	sd_grid_pkg::grid_marks_t marks;
	sd_grid_pkg::blank_list_t blanks;

	// backtracker to streamer
	logic                       solve_done;
	sd_ctrl_pkg::solve_result_t result;

	// marks, blank list, duplicate check
	sd_cell_loader u_loader (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in        (in),
		.load_done (load_done),
		.dup_err   (dup_err),
		.marks     (marks),
		.blanks    (blanks)
	);

	// candidates and depth first search
	sd_backtrack u_backtrack (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_done  (load_done),
		.dup_err    (dup_err),
		.marks      (marks),
		.blanks     (blanks),
		.solve_done (solve_done),
		.result     (result)
	);

	// answers or error code
	sd_answer_out u_answer_out (
		.clk        (clk),
		.rst_n      (rst_n),
		.solve_done (solve_done),
		.result     (result),
		.out_valid  (out_valid),
		.out        (out)
	);

endmodule

// ==== verilog/sd_answer_out.sv ====
`timescale 1ns/1ps

module sd_answer_out (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       solve_done,
	input  sd_ctrl_pkg::solve_result_t result,
	output logic                       out_valid,
	output sd_grid_pkg::digit_t        out
);

	//--------------------------------------------------------------------------
	// declarations
	//--------------------------------------------------------------------------
	sd_ctrl_pkg::solve_result_t res_q;
	// index of the next answer to send
	logic [3:0]                 beat;

	// result held for the burst
	always_ff @(posedge clk) begin
		if (solve_done) begin
			res_q <= result;
		end
	end

	//--------------------------------------------------------------------------
	// output burst
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out <= '0;
			beat <= '0;
		end else if (solve_done) begin
			// first beat straight from the search result
			out_valid <= 1'b1;
			out <= result.fail ? sd_ctrl_pkg::ERR_CODE : result.answers[0];
			beat <= 4'd1;
		end else if (out_valid && !res_q.fail &&
			(beat != 4'(sd_grid_pkg::NUM_BLANKS))) begin
			out <= res_q.answers[beat];
			beat <= beat + 4'd1;
		end else begin
			// error beat or last answer done
			out_valid <= 1'b0;
			out <= '0;
			beat <= '0;
		end
	end

endmodule

// ==== verilog/sd_backtrack.sv ====
`timescale 1ns/1ps

module sd_backtrack (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       load_done,
	input  logic                       dup_err,
	input  sd_grid_pkg::grid_marks_t   marks,
	input  sd_grid_pkg::blank_list_t   blanks,
	output logic                       solve_done,
	output sd_ctrl_pkg::solve_result_t result
);

	//--------------------------------------------------------------------------
	// declarations
	//--------------------------------------------------------------------------
	sd_ctrl_pkg::solve_phase_t phase;
	logic [3:0]                dig_cnt;
	logic [3:0]                cur;
	logic [3:0]                prev;

	// working copy of the marks, changes as digits are placed
	sd_grid_pkg::grid_marks_t  work;
	sd_grid_pkg::grid_marks_t  work_placed;
	sd_grid_pkg::grid_marks_t  work_cleared;
	sd_grid_pkg::blank_list_t  blanks_q;

	// candidate mask per blank
	sd_grid_pkg::digit_mask_t [sd_grid_pkg::NUM_BLANKS-1:0] cand_q;
	sd_grid_pkg::digit_mask_t [sd_grid_pkg::NUM_BLANKS-1:0] cand_next;
	logic                      cand_empty;

	// digit currently placed per blank, 0 when none
	sd_grid_pkg::answer_list_t answers_q;
	sd_grid_pkg::answer_list_t answers_placed;

	sd_grid_pkg::blank_pos_t   cur_pos;
	sd_grid_pkg::blank_pos_t   prev_pos;
	sd_grid_pkg::digit_t       cur_dig;
	sd_grid_pkg::digit_t       next_dig;
	sd_grid_pkg::digit_mask_t  used_mask;
	sd_grid_pkg::digit_mask_t  low_mask;
	sd_grid_pkg::digit_mask_t  try_mask;
	sd_grid_pkg::digit_mask_t  place_bit;
	sd_grid_pkg::digit_mask_t  prev_bit;

	// smallest digit in a mask, 0 if empty
	function automatic sd_grid_pkg::digit_t lowest_digit(input sd_grid_pkg::digit_mask_t m);
		sd_grid_pkg::digit_t d;
		d = '0;
		for (int i = sd_grid_pkg::GRID_N - 1; i >= 0; i--) begin
			if (m[i]) begin
				d = sd_grid_pkg::digit_t'(i + 1);
			end
		end
		return d;
	endfunction

	//--------------------------------------------------------------------------
	// candidate pass
	//--------------------------------------------------------------------------
	// one digit per cycle over all blanks
	always_comb begin
		cand_next = cand_q;
		cand_empty = 1'b0;
		for (int k = 0; k < sd_grid_pkg::NUM_BLANKS; k++) begin
			cand_next[k][dig_cnt] = ~(work.rows[blanks_q[k].row][dig_cnt] |
				work.cols[blanks_q[k].col][dig_cnt] |
				work.boxes[blanks_q[k].box][dig_cnt]);
			if (cand_next[k] == '0) begin
				cand_empty = 1'b1;
			end
		end
	end

	//--------------------------------------------------------------------------
	// search datapath
	//--------------------------------------------------------------------------
	assign cur_pos = blanks_q[cur];
	assign cur_dig = answers_q[cur];

	// digits blocked by the current unit marks
	assign used_mask = work.rows[cur_pos.row] | work.cols[cur_pos.col] |
		work.boxes[cur_pos.box];

	// digits up to the current one are already tried
	assign low_mask = (sd_grid_pkg::digit_mask_t'(1) << cur_dig) -
		sd_grid_pkg::digit_mask_t'(1);
	assign try_mask = cand_q[cur] & ~low_mask & ~used_mask;
	assign next_dig = lowest_digit(try_mask);
	assign place_bit = sd_grid_pkg::digit_onehot(next_dig);

	// blank to return to on backtrack
	assign prev = cur - 4'd1;
	assign prev_pos = blanks_q[prev];
	assign prev_bit = sd_grid_pkg::digit_onehot(answers_q[prev]);

	always_comb begin
		work_placed = work;
		work_placed.rows[cur_pos.row] = work.rows[cur_pos.row] | place_bit;
		work_placed.cols[cur_pos.col] = work.cols[cur_pos.col] | place_bit;
		work_placed.boxes[cur_pos.box] = work.boxes[cur_pos.box] | place_bit;

		work_cleared = work;
		work_cleared.rows[prev_pos.row] = work.rows[prev_pos.row] & ~prev_bit;
		work_cleared.cols[prev_pos.col] = work.cols[prev_pos.col] & ~prev_bit;
		work_cleared.boxes[prev_pos.box] = work.boxes[prev_pos.box] & ~prev_bit;

		answers_placed = answers_q;
		answers_placed[cur] = next_dig;
	end

	//--------------------------------------------------------------------------
	// FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= sd_ctrl_pkg::PH_IDLE;
			dig_cnt <= '0;
			cur <= '0;
			answers_q <= '0;
			solve_done <= 1'b0;
		end else begin
			solve_done <= 1'b0;
			if (load_done) begin
				dig_cnt <= '0;
				cur <= '0;
				answers_q <= '0;
				// duplicate given ends the puzzle at once
				if (dup_err) begin
					solve_done <= 1'b1;
					phase <= sd_ctrl_pkg::PH_IDLE;
				end else begin
					phase <= sd_ctrl_pkg::PH_CAND;
				end
			end else begin
				case (phase)
					sd_ctrl_pkg::PH_CAND: begin
						if (dig_cnt == 4'(sd_grid_pkg::GRID_N - 1)) begin
							dig_cnt <= '0;
							// a blank with no candidate
							if (cand_empty) begin
								solve_done <= 1'b1;
								phase <= sd_ctrl_pkg::PH_IDLE;
							end else begin
								phase <= sd_ctrl_pkg::PH_TRY;
							end
						end else begin
							dig_cnt <= dig_cnt + 4'd1;
						end
					end
					sd_ctrl_pkg::PH_TRY: begin
						if (next_dig != '0) begin
							answers_q <= answers_placed;
							// last blank placed
							if (cur == 4'(sd_grid_pkg::NUM_BLANKS - 1)) begin
								solve_done <= 1'b1;
								phase <= sd_ctrl_pkg::PH_IDLE;
							end else begin
								cur <= cur + 4'd1;
							end
						end else begin
							// next visit starts from digit 1 again
							answers_q[cur] <= '0;
							// first blank exhausted, no completion
							if (cur == '0) begin
								solve_done <= 1'b1;
								phase <= sd_ctrl_pkg::PH_IDLE;
							end else begin
								phase <= sd_ctrl_pkg::PH_BACK;
							end
						end
					end
					sd_ctrl_pkg::PH_BACK: begin
						cur <= prev;
						phase <= sd_ctrl_pkg::PH_TRY;
					end
					default: begin
						phase <= sd_ctrl_pkg::PH_IDLE;
					end
				endcase
			end
		end
	end

	//--------------------------------------------------------------------------
	// working marks, candidates, result
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load_done) begin
			work <= marks;
			blanks_q <= blanks;
			result.fail <= dup_err;
		end else begin
			case (phase)
				sd_ctrl_pkg::PH_CAND: begin
					cand_q <= cand_next;
					if (dig_cnt == 4'(sd_grid_pkg::GRID_N - 1)) begin
						result.fail <= cand_empty;
					end
				end
				sd_ctrl_pkg::PH_TRY: begin
					if (next_dig != '0) begin
						work <= work_placed;
					end
					result.fail <= (next_dig == '0);
					result.answers <= answers_placed;
				end
				sd_ctrl_pkg::PH_BACK: begin
					// undo the previous blank
					work <= work_cleared;
				end
			endcase
		end
	end

endmodule

// ==== verilog/sd_cell_loader.sv ====
`timescale 1ns/1ps

module sd_cell_loader (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  sd_grid_pkg::digit_t      in,
	output logic                     load_done,
	output logic                     dup_err,
	output sd_grid_pkg::grid_marks_t marks,
	output sd_grid_pkg::blank_list_t blanks
);

	//--------------------------------------------------------------------------
	// declarations
	//--------------------------------------------------------------------------
	logic [3:0]               cnt_row;
	logic [3:0]               cnt_col;
	logic [3:0]               cnt_box;
	logic [3:0]               blank_cnt;
	logic [3:0]               blank_idx;
	logic                     first_cell;
	logic                     last_cell;
	logic                     dup_base;
	logic                     dup_hit;
	sd_grid_pkg::digit_mask_t digit_bit;
	sd_grid_pkg::grid_marks_t marks_base;
	sd_grid_pkg::grid_marks_t marks_next;
	sd_grid_pkg::blank_pos_t  cur_pos;

	// box number from band and stack
	function automatic logic [3:0] box_of(input logic [3:0] r, input logic [3:0] c);
		logic [3:0] band;
		logic [3:0] stack;
		band = r / 4'd3;
		stack = c / 4'd3;
		return 4'((band * 4'd3) + stack);
	endfunction

	//--------------------------------------------------------------------------
	// cell position
	//--------------------------------------------------------------------------
	assign cnt_box = box_of(cnt_row, cnt_col);
	assign first_cell = (cnt_row == '0) && (cnt_col == '0);
	assign last_cell = (cnt_row == 4'(sd_grid_pkg::GRID_N - 1)) &&
		(cnt_col == 4'(sd_grid_pkg::GRID_N - 1));

	assign cur_pos.row = cnt_row;
	assign cur_pos.col = cnt_col;
	assign cur_pos.box = cnt_box;

	//--------------------------------------------------------------------------
	// marks update
	//--------------------------------------------------------------------------
	// first cell starts from an empty grid
	assign marks_base = first_cell ? '0 : marks;
	assign blank_idx = first_cell ? '0 : blank_cnt;
	assign dup_base = first_cell ? 1'b0 : dup_err;

	// zero for a blank so nothing is marked
	assign digit_bit = sd_grid_pkg::digit_onehot(in);

	// digit already seen in this row, column or box
	assign dup_hit = |(digit_bit & (marks_base.rows[cnt_row] |
		marks_base.cols[cnt_col] | marks_base.boxes[cnt_box]));

	always_comb begin
		marks_next = marks_base;
		marks_next.rows[cnt_row] = marks_base.rows[cnt_row] | digit_bit;
		marks_next.cols[cnt_col] = marks_base.cols[cnt_col] | digit_bit;
		marks_next.boxes[cnt_box] = marks_base.boxes[cnt_box] | digit_bit;
	end

	//--------------------------------------------------------------------------
	// counters and flags
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_row <= '0;
			cnt_col <= '0;
			blank_cnt <= '0;
			dup_err <= 1'b0;
			load_done <= 1'b0;
		end else begin
			// pulse right after the 81st cell
			load_done <= in_valid && last_cell;
			if (in_valid) begin
				// raster order, wraps after the last cell
				if (cnt_col == 4'(sd_grid_pkg::GRID_N - 1)) begin
					cnt_col <= '0;
					cnt_row <= last_cell ? '0 : cnt_row + 4'd1;
				end else begin
					cnt_col <= cnt_col + 4'd1;
				end
				dup_err <= dup_base | dup_hit;
				// saturates at the list size
				if ((in == '0) && (blank_idx < 4'(sd_grid_pkg::NUM_BLANKS))) begin
					blank_cnt <= blank_idx + 4'd1;
				end else begin
					blank_cnt <= blank_idx;
				end
			end else begin
				cnt_row <= '0;
				cnt_col <= '0;
			end
		end
	end

	// marks and blank list
	always_ff @(posedge clk) begin
		if (in_valid) begin
			marks <= marks_next;
			if ((in == '0) && (blank_idx < 4'(sd_grid_pkg::NUM_BLANKS))) begin
				blanks[blank_idx] <= cur_pos;
			end
		end
	end

endmodule

// ==== verilog/sd_ctrl_pkg.sv ====
package sd_ctrl_pkg;

	//--------------------------------------------------------------------------
	// solver control
	//--------------------------------------------------------------------------
	// single beat sent when the puzzle has no answer
	localparam sd_grid_pkg::digit_t ERR_CODE = 4'd10;

	// backtracker phases
	// idle waits for a loaded puzzle
	// cand builds candidate masks, one digit per cycle
	// try places the next fitting candidate
	// back undoes the previous blank
	typedef enum logic [2:0] {
		PH_IDLE = 3'd0,
		PH_CAND = 3'd1,
		PH_TRY  = 3'd2,
		PH_BACK = 3'd3
	} solve_phase_t;

	// what the search hands to the streamer
	typedef struct packed {
		logic                      fail;
		sd_grid_pkg::answer_list_t answers;
	} solve_result_t;

endpackage

// ==== verilog/sd_grid_pkg.sv ====
package sd_grid_pkg;

	//--------------------------------------------------------------------------
	// puzzle geometry
	//--------------------------------------------------------------------------
	// side length, also the number of digits
	localparam int GRID_N = 9;
	localparam int NUM_CELLS = 81;
	// every puzzle carries exactly this many blanks
	localparam int NUM_BLANKS = 15;

	//--------------------------------------------------------------------------
	// cell and mark types
	//--------------------------------------------------------------------------
	// 0 is blank or unset, 1 to 9 a digit
	typedef logic [3:0] digit_t;

	// bit d-1 set when digit d is present
	typedef logic [GRID_N-1:0] digit_mask_t;

	// where a blank sits
	typedef struct packed {
		logic [3:0] row;
		logic [3:0] col;
		logic [3:0] box;
	} blank_pos_t;

	// digits used per row, column and box
	typedef struct packed {
		digit_mask_t [GRID_N-1:0] rows;
		digit_mask_t [GRID_N-1:0] cols;
		digit_mask_t [GRID_N-1:0] boxes;
	} grid_marks_t;

	// index 0 is the first blank in raster order
	typedef blank_pos_t [NUM_BLANKS-1:0] blank_list_t;
	typedef digit_t [NUM_BLANKS-1:0] answer_list_t;

	// one-hot mask of a digit, empty for a blank
	function automatic digit_mask_t digit_onehot(input digit_t d);
		return (d == '0) ? '0 : (digit_mask_t'(1) << (d - 4'd1));
	endfunction

endpackage
